// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := io_predication_tb
FILELIST := verilog.f
BUILD    := obj_dir
LOG      := sim.log
RUNARGS  := +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) $(RUNARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== dv/io_predication_checker.sv ====
// ------------------------------
// Bound assertions on the predication outputs
// ------------------------------

`timescale 1ns/1ps

module io_predication_checker #(
    parameter int PORT_COUNT = 4
) (
    input logic                  clock,
    input logic                  rst,
    input logic [PORT_COUNT-1:0] a_rden,
    input logic [PORT_COUNT-1:0] b_rden,
    input logic [PORT_COUNT-1:0] wren,
    input logic                  a_is_io,
    input logic                  b_is_io,
    input logic                  w_is_io,
    input logic                  io_ready,
    input io_addr_pkg::word_t    wdata_out
);

    // Number of assertion failures so far
    int failures;

    // Each access addresses at most one port
    enables_one_hot: assert property (@(posedge clock) disable iff (rst)
        $onehot0(a_rden) && $onehot0(b_rden) && $onehot0(wren))
        else begin
            $error("A port enable vector has more than one bit set");
            failures++;
        end

    // An annulled instruction must not touch any port
    enable_needs_ready: assert property (@(posedge clock) disable iff (rst)
        (|a_rden || |b_rden || |wren) |-> io_ready)
        else begin
            $error("A port enable is set while io_ready is low");
            failures++;
        end

    // The cycle after a reset edge shows the idle state
    idle_after_reset: assert property (@(posedge clock)
        rst |=> (a_rden == '0 && b_rden == '0 && wren == '0 && !a_is_io && !b_is_io &&
                 !w_is_io && io_ready && wdata_out == '0))
        else begin
            $error("The outputs are not idle after reset");
            failures++;
        end

endmodule

bind io_predication_top io_predication_checker #(.PORT_COUNT(PORT_COUNT)) checker_i (.*);

// ==== dv/io_predication_monitor.sv ====
// ------------------------------
// Reference model and output compare for the predication top level
// ------------------------------

`timescale 1ns/1ps

module io_predication_monitor #(
    parameter int PORT_COUNT      = 4,
    parameter int PORT_BASE_ADDR  = 1016,
    parameter int PORT_ADDR_WIDTH = 2,
    parameter int NAME_BITS       = 160
) (
    input  logic                  clock,
    input  logic                  rst,
    input  logic [NAME_BITS-1:0]  test_name,
    input  logic                  a_enable,
    input  io_addr_pkg::addr_t    a_addr,
    input  logic                  b_enable,
    input  io_addr_pkg::addr_t    b_addr,
    input  logic                  w_enable,
    input  io_addr_pkg::addr_t    w_addr,
    input  logic [PORT_COUNT-1:0] read_ef,
    input  logic [PORT_COUNT-1:0] write_ef,
    input  io_addr_pkg::word_t    wdata,
    input  logic [PORT_COUNT-1:0] a_rden,
    input  logic [PORT_COUNT-1:0] b_rden,
    input  logic [PORT_COUNT-1:0] wren,
    input  logic                  a_is_io,
    input  logic                  b_is_io,
    input  logic                  w_is_io,
    input  logic                  io_ready,
    input  io_addr_pkg::word_t    wdata_out,
    output int                    check_count,
    output int                    error_count
);

    // Inputs seen at a falling edge are sampled on the next rising edge
    // Their results show up two rising edges later, so three falling edges on
    localparam int DEPTH = io_pipe_pkg::PRED_LATENCY;

    localparam logic [NAME_BITS-1:0] RESET_NAME = NAME_BITS'("reset");

    typedef struct packed {
        logic [NAME_BITS-1:0]  name;
        logic                  a_enable;
        io_addr_pkg::addr_t    a_addr;
        logic                  b_enable;
        io_addr_pkg::addr_t    b_addr;
        logic                  w_enable;
        io_addr_pkg::addr_t    w_addr;
        logic [PORT_COUNT-1:0] read_ef;
        logic [PORT_COUNT-1:0] write_ef;
        io_addr_pkg::word_t    wdata;
    } access_t;

    access_t history [DEPTH];

    // ------------------------------
    // Model
    // ------------------------------

    // I/O addresses share everything above the port index with the base
    function automatic logic in_window(io_addr_pkg::addr_t addr);
        return (int'(addr) >> PORT_ADDR_WIDTH) == (PORT_BASE_ADDR >> PORT_ADDR_WIDTH);
    endfunction

    function automatic logic [PORT_COUNT-1:0] port_select(logic enable, io_addr_pkg::addr_t addr);
        logic [PORT_COUNT-1:0] sel;
        int                    idx;
        sel = '0;
        idx = int'(addr) % (1 << PORT_ADDR_WIDTH);
        if (enable && in_window(addr) && idx < PORT_COUNT) begin
            sel[idx] = 1'b1;
        end
        return sel;
    endfunction

    // A mapped port that sits off its ready level blocks the instruction
    function automatic logic port_blocked(logic enable, io_addr_pkg::addr_t addr,
                                          logic [PORT_COUNT-1:0] ef, logic ready_level);
        int idx;
        idx = int'(addr) % (1 << PORT_ADDR_WIDTH);
        if (port_select(enable, addr) == '0) begin
            return 1'b0;
        end
        return ef[idx] != ready_level;
    endfunction

    task automatic check_value(input logic [NAME_BITS-1:0] name, input string field,
                               input io_addr_pkg::word_t expected,
                               input io_addr_pkg::word_t actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("[ERROR] %0s: %0s expected %h actual %h", name, field, expected, actual);
        end
    endtask

    // ------------------------------
    // Compare
    // ------------------------------

    always @(negedge clock) begin
        access_t               old;
        logic [PORT_COUNT-1:0] sel_a;
        logic [PORT_COUNT-1:0] sel_b;
        logic [PORT_COUNT-1:0] sel_w;
        logic                  ready;
        if (rst) begin
            // Reset empties the pipeline so idle accesses are expected
            for (int i = 0; i < DEPTH; i++) begin
                history[i]      = '0;
                history[i].name = RESET_NAME;
            end
        end else begin
            old   = history[DEPTH-1];
            sel_a = port_select(old.a_enable, old.a_addr);
            sel_b = port_select(old.b_enable, old.b_addr);
            sel_w = port_select(old.w_enable, old.w_addr);
            ready = !(port_blocked(old.a_enable, old.a_addr, old.read_ef,
                                   io_pipe_pkg::READ_READY_STATE) ||
                      port_blocked(old.b_enable, old.b_addr, old.read_ef,
                                   io_pipe_pkg::READ_READY_STATE) ||
                      port_blocked(old.w_enable, old.w_addr, old.write_ef,
                                   io_pipe_pkg::WRITE_READY_STATE));
            check_value(old.name, "io_ready", io_addr_pkg::word_t'(ready),
                        io_addr_pkg::word_t'(io_ready));
            check_value(old.name, "a_rden", io_addr_pkg::word_t'(ready ? sel_a : '0),
                        io_addr_pkg::word_t'(a_rden));
            check_value(old.name, "b_rden", io_addr_pkg::word_t'(ready ? sel_b : '0),
                        io_addr_pkg::word_t'(b_rden));
            check_value(old.name, "wren", io_addr_pkg::word_t'(ready ? sel_w : '0),
                        io_addr_pkg::word_t'(wren));
            check_value(old.name, "a_is_io",
                        io_addr_pkg::word_t'(old.a_enable && in_window(old.a_addr)),
                        io_addr_pkg::word_t'(a_is_io));
            check_value(old.name, "b_is_io",
                        io_addr_pkg::word_t'(old.b_enable && in_window(old.b_addr)),
                        io_addr_pkg::word_t'(b_is_io));
            check_value(old.name, "w_is_io",
                        io_addr_pkg::word_t'(old.w_enable && in_window(old.w_addr)),
                        io_addr_pkg::word_t'(w_is_io));
            // Write data travels whether or not the write is enabled
            check_value(old.name, "wdata_out", old.wdata, wdata_out);
            for (int i = DEPTH - 1; i > 0; i--) begin
                history[i] = history[i-1];
            end
            history[0].name     = test_name;
            history[0].a_enable = a_enable;
            history[0].a_addr   = a_addr;
            history[0].b_enable = b_enable;
            history[0].b_addr   = b_addr;
            history[0].w_enable = w_enable;
            history[0].w_addr   = w_addr;
            history[0].read_ef  = read_ef;
            history[0].write_ef = write_ef;
            history[0].wdata    = wdata;
        end
    end

endmodule

// ==== dv/io_predication_tb.sv ====
// ------------------------------
// Testbench for the predication top level with table and random stimulus
// ------------------------------

`timescale 1ns/1ps

module io_predication_tb;

    // Three ports in a four-address window leave index 3 unmapped
    localparam int PORT_COUNT      = 3;
    localparam int PORT_BASE_ADDR  = 1016;
    localparam int PORT_ADDR_WIDTH = 2;
    localparam int NAME_BITS       = 8 * 20;
    localparam int RANDOM_COUNT    = 200;

    localparam io_addr_pkg::addr_t P0     = io_addr_pkg::addr_t'(PORT_BASE_ADDR);
    localparam io_addr_pkg::addr_t P1     = io_addr_pkg::addr_t'(PORT_BASE_ADDR + 1);
    localparam io_addr_pkg::addr_t P2     = io_addr_pkg::addr_t'(PORT_BASE_ADDR + 2);
    localparam io_addr_pkg::addr_t P3     = io_addr_pkg::addr_t'(PORT_BASE_ADDR + 3);
    localparam io_addr_pkg::addr_t LOW    = io_addr_pkg::addr_t'(0);
    localparam io_addr_pkg::addr_t MID    = io_addr_pkg::addr_t'(512);
    localparam io_addr_pkg::addr_t BELOW  = io_addr_pkg::addr_t'(PORT_BASE_ADDR - 1);

    typedef struct packed {
        logic [NAME_BITS-1:0]  name;
        logic                  a_enable;
        io_addr_pkg::addr_t    a_addr;
        logic                  b_enable;
        io_addr_pkg::addr_t    b_addr;
        logic                  w_enable;
        io_addr_pkg::addr_t    w_addr;
        logic [PORT_COUNT-1:0] read_ef;
        logic [PORT_COUNT-1:0] write_ef;
        io_addr_pkg::word_t    wdata;
    } stim_t;

    logic                  clock;
    logic                  rst;
    logic [NAME_BITS-1:0]  test_name;
    logic                  a_enable;
    io_addr_pkg::addr_t    a_addr;
    logic                  b_enable;
    io_addr_pkg::addr_t    b_addr;
    logic                  w_enable;
    io_addr_pkg::addr_t    w_addr;
    logic [PORT_COUNT-1:0] read_ef;
    logic [PORT_COUNT-1:0] write_ef;
    io_addr_pkg::word_t    wdata;
    logic [PORT_COUNT-1:0] a_rden;
    logic [PORT_COUNT-1:0] b_rden;
    logic [PORT_COUNT-1:0] wren;
    logic                  a_is_io;
    logic                  b_is_io;
    logic                  w_is_io;
    logic                  io_ready;
    io_addr_pkg::word_t    wdata_out;
    int                    check_count;
    int                    error_count;

    stim_t stim_q [$];

    io_predication_top #(
        .PORT_COUNT      (PORT_COUNT),
        .PORT_BASE_ADDR  (PORT_BASE_ADDR),
        .PORT_ADDR_WIDTH (PORT_ADDR_WIDTH)
    ) io_predication_top_i (.*);

    io_predication_monitor #(
        .PORT_COUNT      (PORT_COUNT),
        .PORT_BASE_ADDR  (PORT_BASE_ADDR),
        .PORT_ADDR_WIDTH (PORT_ADDR_WIDTH),
        .NAME_BITS       (NAME_BITS)
    ) monitor_i (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Right-aligned characters so the name prints without padding
    function automatic logic [NAME_BITS-1:0] pack_name(string text);
        logic [NAME_BITS-1:0] bits;
        bits = '0;
        for (int i = 0; i < text.len(); i++) begin
            bits = {bits[NAME_BITS-9:0], text.getc(i)};
        end
        return bits;
    endfunction

    task automatic add_entry(input string name, input logic a_en, input io_addr_pkg::addr_t a_ad,
                             input logic b_en, input io_addr_pkg::addr_t b_ad,
                             input logic w_en, input io_addr_pkg::addr_t w_ad,
                             input logic [PORT_COUNT-1:0] r_ef, input logic [PORT_COUNT-1:0] w_ef,
                             input io_addr_pkg::word_t data);
        stim_t s;
        s = {pack_name(name), a_en, a_ad, b_en, b_ad, w_en, w_ad, r_ef, w_ef, data};
        stim_q.push_back(s);
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------

    // Read ports are ready at 1 and write ports at 0
    task automatic build_table();
        add_entry("ready_all", 1'b1, P0, 1'b1, P1, 1'b1, P2, 3'b111, 3'b000, 36'h0_1234_5678);
        add_entry("ready_same_port", 1'b1, P2, 1'b1, P2, 1'b1, P0, 3'b111, 3'b000,
                  36'hA_BCDE_F012);
        add_entry("a_port_empty", 1'b1, P0, 1'b1, P1, 1'b1, P2, 3'b110, 3'b000, 36'h1_1111_1111);
        add_entry("b_port_empty", 1'b1, P0, 1'b1, P1, 1'b1, P2, 3'b101, 3'b000, 36'h2_2222_2222);
        add_entry("w_port_full", 1'b1, P0, 1'b1, P1, 1'b1, P2, 3'b111, 3'b100, 36'h3_3333_3333);
        // Busy ports that no access selects must not annul
        add_entry("other_ports_busy", 1'b1, P0, 1'b0, P1, 1'b1, P0, 3'b001, 3'b110,
                  36'h4_4444_4444);
        add_entry("non_io_addrs", 1'b1, LOW, 1'b1, MID, 1'b1, BELOW, 3'b000, 3'b111,
                  36'h5_5555_5555);
        add_entry("disabled_io", 1'b0, P0, 1'b0, P1, 1'b0, P2, 3'b000, 3'b111, 36'h6_6666_6666);
        add_entry("unmapped_index", 1'b1, P3, 1'b1, P3, 1'b1, P3, 3'b000, 3'b111,
                  36'h7_7777_7777);
        add_entry("unmapped_mixed", 1'b1, P3, 1'b1, P1, 1'b1, P0, 3'b111, 3'b000,
                  36'h8_8888_8888);
        // Consecutive entries keep three instructions in flight
        add_entry("b2b_write_p1", 1'b1, P1, 1'b1, P0, 1'b1, P1, 3'b111, 3'b000, 36'hF_0000_0001);
        add_entry("b2b_annul", 1'b1, P2, 1'b1, P0, 1'b1, P1, 3'b111, 3'b010, 36'hF_0000_0002);
        add_entry("b2b_write_p2", 1'b1, P0, 1'b1, P0, 1'b1, P2, 3'b111, 3'b000, 36'hF_0000_0003);
        add_entry("b2b_read_only", 1'b1, P1, 1'b1, P2, 1'b0, P2, 3'b111, 3'b000,
                  36'hF_0000_0004);
    endtask

    // Three in four addresses land in the window
    function automatic io_addr_pkg::addr_t pick_address();
        if ($urandom % 4 != 0) begin
            return io_addr_pkg::addr_t'(PORT_BASE_ADDR + int'($urandom % (1 << PORT_ADDR_WIDTH)));
        end
        return io_addr_pkg::addr_t'($urandom);
    endfunction

    // Ports are mostly ready so that not every instruction is annulled
    function automatic stim_t random_entry();
        stim_t s;
        s.name     = pack_name("random");
        s.a_enable = ($urandom % 8) != 0;
        s.a_addr   = pick_address();
        s.b_enable = ($urandom % 8) != 0;
        s.b_addr   = pick_address();
        s.w_enable = ($urandom % 8) != 0;
        s.w_addr   = pick_address();
        s.read_ef  = ($urandom % 4 == 0) ? PORT_COUNT'($urandom) : '1;
        s.write_ef = ($urandom % 4 == 0) ? PORT_COUNT'($urandom) : '0;
        s.wdata    = io_addr_pkg::word_t'({$urandom, $urandom});
        return s;
    endfunction

    task automatic apply_entry(input stim_t s);
        @(posedge clock);
        #1;
        test_name = s.name;
        a_enable  = s.a_enable;
        a_addr    = s.a_addr;
        b_enable  = s.b_enable;
        b_addr    = s.b_addr;
        w_enable  = s.w_enable;
        w_addr    = s.w_addr;
        read_ef   = s.read_ef;
        write_ef  = s.write_ef;
        wdata     = s.wdata;
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        int          assert_failures;
        stim_t       idle;
        void'($urandom(75));
        rst  = 1'b1;
        idle = '0;
        idle.name = pack_name("drain");
        test_name = pack_name("reset");
        a_enable  = 1'b0;
        a_addr    = '0;
        b_enable  = 1'b0;
        b_addr    = '0;
        w_enable  = 1'b0;
        w_addr    = '0;
        read_ef   = '0;
        write_ef  = '0;
        wdata     = '0;
        build_table();
        repeat (5) @(posedge clock);
        #1;
        rst = 1'b0;
        foreach (stim_q[i]) begin
            apply_entry(stim_q[i]);
        end
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            apply_entry(random_entry());
        end
        // Idle cycles let the last accesses reach the outputs
        repeat (io_pipe_pkg::PRED_LATENCY + 1) apply_entry(idle);
        @(negedge clock);
        assert_failures = io_predication_top_i.checker_i.failures;
        $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
                 check_count, error_count, assert_failures);
        if (error_count == 0 && assert_failures == 0 && check_count > 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin : watchdog
        int limit_cycles;
        @(posedge clock);
        limit_cycles = (stim_q.size() + RANDOM_COUNT) * 10 + 100;
        repeat (limit_cycles) @(posedge clock);
        $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== rtl/io_access_if.sv ====
// ------------------------------
// One memory access between the top level and a predication block
// ------------------------------

`timescale 1ns/1ps

interface io_access_if #(
    parameter int PORT_COUNT = 4
);

    // Request side, sampled on the same edge
    logic                    enable;
    io_addr_pkg::addr_t      addr;
    logic [PORT_COUNT-1:0]   ef;

    // Result side, each at its own pipeline stage
    logic                    not_ready;
    logic                    is_io;
    logic [PORT_COUNT-1:0]   port_sel;

    // The predication block returns the check results
    modport pred (
        input  enable,
        input  addr,
        input  ef,
        output not_ready,
        output is_io,
        output port_sel
    );

    // The top level presents the access and reads back the results
    modport core (
        output enable,
        output addr,
        output ef,
        input  not_ready,
        input  is_io,
        input  port_sel
    );

endinterface

// ==== rtl/io_active.sv ====
// ------------------------------
// One-hot port select from an address
// ------------------------------

`timescale 1ns/1ps

module io_active #(
    parameter int PORT_COUNT      = 4,
    parameter int PORT_BASE_ADDR  = 1016,
    parameter int PORT_ADDR_WIDTH = 2
) (
    input  logic                  enable,
    input  io_addr_pkg::addr_t    addr,
    output logic [PORT_COUNT-1:0] active
);

    localparam int AW = io_addr_pkg::ADDR_WIDTH;

    // Base address in the address type so its upper bits can be sliced
    localparam io_addr_pkg::addr_t BASE = io_addr_pkg::addr_t'(PORT_BASE_ADDR);

    logic                       in_window;
    logic [PORT_ADDR_WIDTH-1:0] port_index;

    // The window is every address that shares the upper bits of the base
    assign in_window  = (addr[AW-1:PORT_ADDR_WIDTH] == BASE[AW-1:PORT_ADDR_WIDTH]);

    // The port number sits in the low bits of the address
    assign port_index = addr[PORT_ADDR_WIDTH-1:0];

    // One compare per port keeps the select one-hot
    // An index at or above PORT_COUNT matches no bit and so selects nothing
    for (genvar i = 0; i < PORT_COUNT; i++) begin : g_decode
        assign active[i] = enable && in_window &&
                           (port_index == PORT_ADDR_WIDTH'(i));
    end

endmodule

// ==== rtl/io_addr_pkg.sv ====
// ------------------------------
// Address and data word widths, with the typedefs built on them
// ------------------------------

package io_addr_pkg;

    // ------------------------------
    // Widths
    // ------------------------------

    // Width of a processor data-memory address
    localparam int ADDR_WIDTH = 10;

    // Width of a data word written to a port
    localparam int WORD_WIDTH = 36;

    // ------------------------------
    // Types
    // ------------------------------

    // One memory address, whether it falls in the I/O window or not
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // One write data word as it travels down the write pipeline
    typedef logic [WORD_WIDTH-1:0] word_t;

endpackage

// ==== rtl/io_check.sv ====
// ------------------------------
// Two-stage I/O window and port readiness check
// ------------------------------

`timescale 1ns/1ps

module io_check #(
    parameter bit READY_STATE     = 1'b1,
    parameter int PORT_COUNT      = 4,
    parameter int PORT_BASE_ADDR  = 1016,
    parameter int PORT_ADDR_WIDTH = 2
) (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  enable,
    input  io_addr_pkg::addr_t    addr,
    input  logic [PORT_COUNT-1:0] ef,
    output logic                  not_ready,
    output logic                  is_io_raw
);

    localparam int AW = io_addr_pkg::ADDR_WIDTH;

    localparam io_addr_pkg::addr_t BASE = io_addr_pkg::addr_t'(PORT_BASE_ADDR);

    // ------------------------------
    // Stage 1
    // ------------------------------

    logic                  match_s1;
    io_addr_pkg::addr_t    addr_s1;
    logic [PORT_COUNT-1:0] ef_s1;

    // Only a real access inside the window counts as an I/O access
    // The levels are taken on the same edge as the address
    always_ff @(posedge clock) begin
        if (rst) begin
            match_s1 <= 1'b0;
            addr_s1  <= '0;
            ef_s1    <= '0;
        end else begin
            match_s1 <= enable && (addr[AW-1:PORT_ADDR_WIDTH] == BASE[AW-1:PORT_ADDR_WIDTH]);
            addr_s1  <= addr;
            ef_s1    <= ef;
        end
    end

    // ------------------------------
    // Stage 2
    // ------------------------------

    logic [PORT_COUNT-1:0] sel_s1;
    logic [PORT_COUNT-1:0] ef_masked;

    // Select the addressed port, gated by the registered window match
    io_active #(
        .PORT_COUNT      (PORT_COUNT),
        .PORT_BASE_ADDR  (PORT_BASE_ADDR),
        .PORT_ADDR_WIDTH (PORT_ADDR_WIDTH)
    ) port_decode (
        .enable (match_s1),
        .addr   (addr_s1),
        .active (sel_s1)
    );

    // A bit is set where the selected port sits away from its ready level
    // Unmapped indices select no port, so they never show as not ready
    assign ef_masked = sel_s1 & (ef_s1 ^ {PORT_COUNT{READY_STATE}});

    always_ff @(posedge clock) begin
        if (rst) begin
            not_ready <= 1'b0;
            is_io_raw <= 1'b0;
        end else begin
            not_ready <= |ef_masked;
            is_io_raw <= match_s1;
        end
    end

endmodule

// ==== rtl/io_pipe_pkg.sv ====
// ------------------------------
// Predication latency and port ready levels
// ------------------------------

package io_pipe_pkg;

    // Cycles from an access entering to its enables and io_ready appearing
    localparam int PRED_LATENCY = 3;

    // A read port is ready once it holds data, so full (1) is ready
    localparam bit READ_READY_STATE = 1'b1;

    // A write port is ready while it has room, so not full (0) is ready
    localparam bit WRITE_READY_STATE = 1'b0;

endpackage

// ==== rtl/io_predication_top.sv ====
// ------------------------------
// Three access paths and the shared io_ready verdict
// ------------------------------

`timescale 1ns/1ps

module io_predication_top #(
    parameter int PORT_COUNT      = 4,
    parameter int PORT_BASE_ADDR  = 1016,
    parameter int PORT_ADDR_WIDTH = 2
) (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  a_enable,
    input  io_addr_pkg::addr_t    a_addr,
    input  logic                  b_enable,
    input  io_addr_pkg::addr_t    b_addr,
    input  logic                  w_enable,
    input  io_addr_pkg::addr_t    w_addr,
    input  logic [PORT_COUNT-1:0] read_ef,
    input  logic [PORT_COUNT-1:0] write_ef,
    input  io_addr_pkg::word_t    wdata,
    output logic [PORT_COUNT-1:0] a_rden,
    output logic [PORT_COUNT-1:0] b_rden,
    output logic [PORT_COUNT-1:0] wren,
    output logic                  a_is_io,
    output logic                  b_is_io,
    output logic                  w_is_io,
    output logic                  io_ready,
    output io_addr_pkg::word_t    wdata_out
);

    // ------------------------------
    // Access bundles
    // ------------------------------

    io_access_if #(.PORT_COUNT(PORT_COUNT)) a_acc ();
    io_access_if #(.PORT_COUNT(PORT_COUNT)) b_acc ();
    io_access_if #(.PORT_COUNT(PORT_COUNT)) w_acc ();

    // Both operand reads see the same read port levels
    assign a_acc.enable = a_enable;
    assign a_acc.addr   = a_addr;
    assign a_acc.ef     = read_ef;

    assign b_acc.enable = b_enable;
    assign b_acc.addr   = b_addr;
    assign b_acc.ef     = read_ef;

    assign w_acc.enable = w_enable;
    assign w_acc.addr   = w_addr;
    assign w_acc.ef     = write_ef;

    // ------------------------------
    // Predication paths
    // ------------------------------

    io_read_predication #(
        .PORT_COUNT      (PORT_COUNT),
        .PORT_BASE_ADDR  (PORT_BASE_ADDR),
        .PORT_ADDR_WIDTH (PORT_ADDR_WIDTH)
    ) a_pred (
        .clock    (clock),
        .rst      (rst),
        .acc      (a_acc.pred),
        .io_ready (io_ready),
        .rden     (a_rden)
    );

    io_read_predication #(
        .PORT_COUNT      (PORT_COUNT),
        .PORT_BASE_ADDR  (PORT_BASE_ADDR),
        .PORT_ADDR_WIDTH (PORT_ADDR_WIDTH)
    ) b_pred (
        .clock    (clock),
        .rst      (rst),
        .acc      (b_acc.pred),
        .io_ready (io_ready),
        .rden     (b_rden)
    );

    io_write_predication #(
        .PORT_COUNT      (PORT_COUNT),
        .PORT_BASE_ADDR  (PORT_BASE_ADDR),
        .PORT_ADDR_WIDTH (PORT_ADDR_WIDTH)
    ) w_pred (
        .clock     (clock),
        .rst       (rst),
        .acc       (w_acc.pred),
        .io_ready  (io_ready),
        .wdata     (wdata),
        .wren      (wren),
        .wdata_out (wdata_out)
    );

    // Stage 3 flags go straight out
    assign a_is_io = a_acc.is_io;
    assign b_is_io = b_acc.is_io;
    assign w_is_io = w_acc.is_io;

    // One unready port among the three accesses annuls the whole instruction
    // Out of reset nothing is in flight, so the verdict starts as ready
    always_ff @(posedge clock) begin
        if (rst) begin
            io_ready <= 1'b1;
        end else begin
            io_ready <= ~(a_acc.not_ready | b_acc.not_ready | w_acc.not_ready);
        end
    end

endmodule

// ==== rtl/io_read_predication.sv ====
// ------------------------------
// Read-side predication with gated per-port read enables
// ------------------------------

`timescale 1ns/1ps

module io_read_predication #(
    parameter int PORT_COUNT      = 4,
    parameter int PORT_BASE_ADDR  = 1016,
    parameter int PORT_ADDR_WIDTH = 2
) (
    input  logic                  clock,
    input  logic                  rst,
    io_access_if.pred             acc,
    input  logic                  io_ready,
    output logic [PORT_COUNT-1:0] rden
);

    logic is_io_raw;

    // Window match and readiness of the read port against the full level
    io_check #(
        .READY_STATE     (io_pipe_pkg::READ_READY_STATE),
        .PORT_COUNT      (PORT_COUNT),
        .PORT_BASE_ADDR  (PORT_BASE_ADDR),
        .PORT_ADDR_WIDTH (PORT_ADDR_WIDTH)
    ) read_check (
        .clock     (clock),
        .rst       (rst),
        .enable    (acc.enable),
        .addr      (acc.addr),
        .ef        (acc.ef),
        .not_ready (acc.not_ready),
        .is_io_raw (is_io_raw)
    );

    // ------------------------------
    // Address alignment
    // ------------------------------

    io_addr_pkg::addr_t addr_s1;
    io_addr_pkg::addr_t addr_s2;

    // Two registers bring the address level with is_io_raw
    always_ff @(posedge clock) begin
        if (rst) begin
            addr_s1 <= '0;
            addr_s2 <= '0;
        end else begin
            addr_s1 <= acc.addr;
            addr_s2 <= addr_s1;
        end
    end

    logic [PORT_COUNT-1:0] sel_raw;

    // Port select for the enables, decoded only for confirmed I/O accesses
    io_active #(
        .PORT_COUNT      (PORT_COUNT),
        .PORT_BASE_ADDR  (PORT_BASE_ADDR),
        .PORT_ADDR_WIDTH (PORT_ADDR_WIDTH)
    ) rden_decode (
        .enable (is_io_raw),
        .addr   (addr_s2),
        .active (sel_raw)
    );

    // Stage 3 lines up with io_ready, which the top registers on this edge
    always_ff @(posedge clock) begin
        if (rst) begin
            acc.port_sel <= '0;
            acc.is_io    <= 1'b0;
        end else begin
            acc.port_sel <= sel_raw;
            acc.is_io    <= is_io_raw;
        end
    end

    // Annul the read when any access of the instruction hit an unready port
    assign rden = acc.port_sel & {PORT_COUNT{io_ready}};

endmodule

// ==== rtl/io_write_predication.sv ====
// ------------------------------
// Write-side predication with gated write enable and aligned data
// ------------------------------

`timescale 1ns/1ps

module io_write_predication #(
    parameter int PORT_COUNT      = 4,
    parameter int PORT_BASE_ADDR  = 1016,
    parameter int PORT_ADDR_WIDTH = 2
) (
    input  logic                  clock,
    input  logic                  rst,
    io_access_if.pred             acc,
    input  logic                  io_ready,
    input  io_addr_pkg::word_t    wdata,
    output logic [PORT_COUNT-1:0] wren,
    output io_addr_pkg::word_t    wdata_out
);

    localparam int DEPTH = io_pipe_pkg::PRED_LATENCY;

    logic is_io_raw;

    // Write ports are ready while not full
    io_check #(
        .READY_STATE     (io_pipe_pkg::WRITE_READY_STATE),
        .PORT_COUNT      (PORT_COUNT),
        .PORT_BASE_ADDR  (PORT_BASE_ADDR),
        .PORT_ADDR_WIDTH (PORT_ADDR_WIDTH)
    ) write_check (
        .clock     (clock),
        .rst       (rst),
        .enable    (acc.enable),
        .addr      (acc.addr),
        .ef        (acc.ef),
        .not_ready (acc.not_ready),
        .is_io_raw (is_io_raw)
    );

    io_addr_pkg::addr_t    addr_s1;
    io_addr_pkg::addr_t    addr_s2;
    logic [PORT_COUNT-1:0] sel_raw;

    // Same address alignment as on the read side
    always_ff @(posedge clock) begin
        if (rst) begin
            addr_s1 <= '0;
            addr_s2 <= '0;
        end else begin
            addr_s1 <= acc.addr;
            addr_s2 <= addr_s1;
        end
    end

    io_active #(
        .PORT_COUNT      (PORT_COUNT),
        .PORT_BASE_ADDR  (PORT_BASE_ADDR),
        .PORT_ADDR_WIDTH (PORT_ADDR_WIDTH)
    ) wren_decode (
        .enable (is_io_raw),
        .addr   (addr_s2),
        .active (sel_raw)
    );

    always_ff @(posedge clock) begin
        if (rst) begin
            acc.port_sel <= '0;
            acc.is_io    <= 1'b0;
        end else begin
            acc.port_sel <= sel_raw;
            acc.is_io    <= is_io_raw;
        end
    end

    // The write is dropped entirely when the instruction is annulled
    assign wren = acc.port_sel & {PORT_COUNT{io_ready}};

    // ------------------------------
    // Write data delay line
    // ------------------------------

    io_addr_pkg::word_t wdata_pipe [DEPTH];

    // One register per pipeline stage lands the data with wren
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                wdata_pipe[i] <= '0;
            end
        end else begin
            wdata_pipe[0] <= wdata;
            for (int i = 1; i < DEPTH; i++) begin
                wdata_pipe[i] <= wdata_pipe[i-1];
            end
        end
    end

    assign wdata_out = wdata_pipe[DEPTH-1];

endmodule

// ==== verilog.f ====
rtl/io_addr_pkg.sv
rtl/io_pipe_pkg.sv
rtl/io_access_if.sv
rtl/io_active.sv
rtl/io_check.sv
rtl/io_read_predication.sv
rtl/io_write_predication.sv
rtl/io_predication_top.sv
dv/io_predication_checker.sv
dv/io_predication_monitor.sv
dv/io_predication_tb.sv
